// ==== logic/mips_pkg.sv ====
/*
 * shared widths, constants and encodings for the pipelined mips core
 * every rtl file refers to these by scoped name
 */
package mips_pkg;

   // data and address width
   localparam int word_w = 32;

   typedef logic [word_w-1:0] word_t;
   typedef logic [4:0]        reg_idx_t;

   // pc after reset, start of the text segment
   localparam word_t text_start = 32'h0040_0000;
   // $v0 value that makes a syscall halt the core
   localparam word_t syscall_exit = 32'd10;
   localparam reg_idx_t reg_v0 = 5'd2;

   // primary opcodes in inst[31:26]
   typedef enum logic [5:0] {
      op_special = 6'h00,
      op_j       = 6'h02,
      op_beq     = 6'h04,
      op_bne     = 6'h05,
      op_addi    = 6'h08,
      op_addiu   = 6'h09,
      op_slti    = 6'h0a,
      op_sltiu   = 6'h0b,
      op_andi    = 6'h0c,
      op_ori     = 6'h0d,
      op_xori    = 6'h0e,
      op_lui     = 6'h0f,
      op_lw      = 6'h23,
      op_sw      = 6'h2b
   } opcode_t;

   // funct codes of the special opcode, inst[5:0]
   typedef enum logic [5:0] {
      fn_sll     = 6'h00,
      fn_srl     = 6'h02,
      fn_sra     = 6'h03,
      fn_syscall = 6'h0c,
      fn_add     = 6'h20,
      fn_addu    = 6'h21,
      fn_sub     = 6'h22,
      fn_subu    = 6'h23,
      fn_and     = 6'h24,
      fn_or      = 6'h25,
      fn_xor     = 6'h26,
      fn_nor     = 6'h27,
      fn_slt     = 6'h2a,
      fn_sltu    = 6'h2b
   } funct_t;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
      alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
   } alu_op_t;

   // execute operand source
   typedef enum logic [1:0] {fwd_rf, fwd_mem, fwd_wb} fwd_sel_t;

   // next pc source
   typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump} pc_sel_t;

endpackage

// ==== logic/mips_fetch.sv ====
/*
 * fetch stage pc register
 * loads pc+4, the branch target or the jump target when enabled
 */
module mips_fetch (
   input  logic               clk,
   input  logic               rst_b,
   input  logic               enable,
   input  mips_pkg::pc_sel_t  pc_sel,
   input  mips_pkg::word_t    branch_target,
   input  mips_pkg::word_t    jump_target,
   output mips_pkg::word_t    pc,
   output logic [29:0]        inst_addr
);
   mips_pkg::word_t pc_next;

   always_comb begin
      case (pc_sel)
         mips_pkg::pc_branch: pc_next = branch_target;
         mips_pkg::pc_jump:   pc_next = jump_target;
         default:             pc_next = pc + 32'd4;
      endcase
   end

   // held during a load-use stall and after halt
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= mips_pkg::text_start;
      end else if (enable) begin
         pc <= pc_next;
      end
   end

   // instruction memory is word addressed
   assign inst_addr = pc[mips_pkg::word_w-1:2];

endmodule

// ==== logic/mips_decode.sv ====
/*
 * instruction decoder for the decode stage
 * splits a word into register indices, the immediate and stage controls
 */
module mips_decode (
   input  mips_pkg::word_t    inst,
   output mips_pkg::reg_idx_t rs,
   output mips_pkg::reg_idx_t rt,
   output mips_pkg::reg_idx_t rd_dest,
   output mips_pkg::word_t    imm,
   output mips_pkg::alu_op_t  alu_op,
   output logic               use_imm,
   output logic               reg_we,
   output logic               is_load,
   output logic               is_store,
   output logic               is_branch_eq,
   output logic               is_branch_ne,
   output logic               is_jump,
   output logic               is_syscall,
   output logic [25:0]        jump_index
);
   mips_pkg::opcode_t op;
   mips_pkg::funct_t  fn;
   logic              imm_alu;
   logic              zero_ext;

   assign op = mips_pkg::opcode_t'(inst[31:26]);
   assign fn = mips_pkg::funct_t'(inst[5:0]);
   // opcodes 0x08 to 0x0f are the immediate alu group
   assign imm_alu = (inst[31:29] == 3'b001);
   // logical immediates zero extend, the rest sign extend
   assign zero_ext = op inside {mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori};

   assign rs = inst[25:21];
   // syscall looks at $v0 through the rt read port
   assign rt = is_syscall ? mips_pkg::reg_v0 : inst[20:16];
   // r-type writes rd, immediates and loads write rt
   assign rd_dest = (op == mips_pkg::op_special) ? inst[15:11] : inst[20:16];
   assign imm = zero_ext ? {16'h0, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};
   assign jump_index = inst[25:0];

   always_comb begin
      alu_op = mips_pkg::alu_add;
      use_imm = imm_alu;
      reg_we = imm_alu;
      is_load = 1'b0;
      is_store = 1'b0;
      is_branch_eq = 1'b0;
      is_branch_ne = 1'b0;
      is_jump = 1'b0;
      is_syscall = 1'b0;
      case (op)
         mips_pkg::op_special: begin
            reg_we = 1'b1;
            case (fn)
               mips_pkg::fn_add, mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
               mips_pkg::fn_sub, mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
               mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
               mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
               mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
               mips_pkg::fn_nor:  alu_op = mips_pkg::alu_nor;
               mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
               mips_pkg::fn_sltu: alu_op = mips_pkg::alu_sltu;
               mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
               mips_pkg::fn_srl:  alu_op = mips_pkg::alu_srl;
               mips_pkg::fn_sra:  alu_op = mips_pkg::alu_sra;
               mips_pkg::fn_syscall: begin
                  reg_we = 1'b0;
                  is_syscall = 1'b1;
               end
               // unknown funct runs as a no-op
               default: reg_we = 1'b0;
            endcase
         end
         mips_pkg::op_j:   is_jump = 1'b1;
         mips_pkg::op_beq: is_branch_eq = 1'b1;
         mips_pkg::op_bne: is_branch_ne = 1'b1;
         mips_pkg::op_addi, mips_pkg::op_addiu: alu_op = mips_pkg::alu_add;
         mips_pkg::op_slti:  alu_op = mips_pkg::alu_slt;
         mips_pkg::op_sltiu: alu_op = mips_pkg::alu_sltu;
         mips_pkg::op_andi:  alu_op = mips_pkg::alu_and;
         mips_pkg::op_ori:   alu_op = mips_pkg::alu_or;
         mips_pkg::op_xori:  alu_op = mips_pkg::alu_xor;
         mips_pkg::op_lui:   alu_op = mips_pkg::alu_lui;
         mips_pkg::op_lw: begin
            reg_we = 1'b1;
            use_imm = 1'b1;
            is_load = 1'b1;
         end
         mips_pkg::op_sw: begin
            use_imm = 1'b1;
            is_store = 1'b1;
         end
         // unknown opcode, nothing is written
         default: reg_we = 1'b0;
      endcase
   end

endmodule

// ==== logic/mips_regfile.sv ====
/*
 * 32 entry register file, two reads and one write
 * $zero reads as 0, a read of the entry being written returns the new data
 */
module mips_regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs_idx,
   input  mips_pkg::reg_idx_t rt_idx,
   input  mips_pkg::reg_idx_t wr_idx,
   input  mips_pkg::word_t    wr_data,
   input  logic               we,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data
);
   mips_pkg::word_t regs [32];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wr_idx != '0) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // write-through so decode sees the writeback of the same cycle
   assign rs_data = (rs_idx == '0) ? '0 : (we && rs_idx == wr_idx) ? wr_data : regs[rs_idx];
   assign rt_data = (rt_idx == '0) ? '0 : (we && rt_idx == wr_idx) ? wr_data : regs[rt_idx];

endmodule

// ==== logic/mips_alu.sv ====
/*
 * execute stage alu
 * shifts act on b by the constant shamt, lui moves b[15:0] to the upper half
 */
module mips_alu (
   input  mips_pkg::alu_op_t op,
   input  mips_pkg::word_t   a,
   input  mips_pkg::word_t   b,
   input  logic [4:0]        shamt,
   output mips_pkg::word_t   result,
   output logic              equal
);

   always_comb begin
      case (op)
         mips_pkg::alu_sub:  result = a - b;
         mips_pkg::alu_and:  result = a & b;
         mips_pkg::alu_or:   result = a | b;
         mips_pkg::alu_xor:  result = a ^ b;
         mips_pkg::alu_nor:  result = ~(a | b);
         // set on less than, signed and unsigned
         mips_pkg::alu_slt:  result = mips_pkg::word_t'($signed(a) < $signed(b));
         mips_pkg::alu_sltu: result = mips_pkg::word_t'(a < b);
         mips_pkg::alu_sll:  result = b << shamt;
         mips_pkg::alu_srl:  result = b >> shamt;
         mips_pkg::alu_sra:  result = mips_pkg::word_t'($signed(b) >>> shamt);
         mips_pkg::alu_lui:  result = {b[15:0], 16'h0};
         default:            result = a + b;
      endcase
   end

   // beq and bne compare the two forwarded operands
   assign equal = (a == b);

endmodule

// ==== logic/mips_hazard.sv ====
/*
 * hazard unit with the forwarding selects for execute, the load-use stall and the redirect flush
 * purely combinational, evaluated every cycle
 */
module mips_hazard (
   input  mips_pkg::reg_idx_t id_rs,
   input  mips_pkg::reg_idx_t id_rt,
   input  mips_pkg::reg_idx_t ex_rs,
   input  mips_pkg::reg_idx_t ex_rt,
   input  mips_pkg::reg_idx_t ex_dest,
   input  logic               ex_reg_we,
   input  logic               ex_is_load,
   input  mips_pkg::reg_idx_t mem_dest,
   input  logic               mem_reg_we,
   input  mips_pkg::reg_idx_t wb_dest,
   input  logic               wb_reg_we,
   input  logic               redirect,
   output logic               stall,
   output logic               flush,
   output mips_pkg::fwd_sel_t fwd_a,
   output mips_pkg::fwd_sel_t fwd_b
);
   logic mem_live;
   logic wb_live;
   logic load_use;

   // a producer counts only if it writes a nonzero register
   assign mem_live = mem_reg_we && (mem_dest != '0);
   assign wb_live = wb_reg_we && (wb_dest != '0);

   // memory stage is newer, so it wins over writeback
   assign fwd_a = (mem_live && mem_dest == ex_rs) ? mips_pkg::fwd_mem :
                  (wb_live && wb_dest == ex_rs)   ? mips_pkg::fwd_wb  : mips_pkg::fwd_rf;
   assign fwd_b = (mem_live && mem_dest == ex_rt) ? mips_pkg::fwd_mem :
                  (wb_live && wb_dest == ex_rt)   ? mips_pkg::fwd_wb  : mips_pkg::fwd_rf;

   // load in execute feeding the instruction in decode
   // rt is compared even when decode only writes it, which costs at most one extra stall
   assign load_use = ex_is_load && ex_reg_we && (ex_dest != '0) &&
                     (ex_dest == id_rs || ex_dest == id_rt);

   // the redirect kills decode anyway, so it overrides the stall
   assign flush = redirect;
   assign stall = load_use && !redirect;

endmodule

// ==== logic/mips_core.sv ====
/*
 * five stage mips core with fetch, decode, execute, memory and writeback
 * separate single-cycle instruction and data ports, halted marks the end
 */
module mips_core (
   input  logic              clk,
   input  logic              rst_b,
   input  mips_pkg::word_t   inst,
   input  mips_pkg::word_t   mem_rdata,
   output logic [29:0]       inst_addr,
   output logic [29:0]       mem_addr,
   output mips_pkg::word_t   mem_wdata,
   output logic              mem_we,
   output logic              halted
);
   mips_pkg::word_t    pc, branch_target, jump_target, if_id_pc, if_id_inst;
   mips_pkg::pc_sel_t  pc_sel;
   logic               stall, flush, id_kill, redirect, ex_equal;
   // decode stage
   mips_pkg::reg_idx_t id_rs, id_rt, id_dest;
   mips_pkg::word_t    id_imm, id_rs_val, id_rt_val;
   mips_pkg::alu_op_t  id_alu_op;
   logic               id_use_imm, id_reg_we, id_is_load, id_is_store;
   logic               id_is_beq, id_is_bne, id_is_jump, id_is_syscall;
   logic [25:0]        id_jump_index;
   // execute stage
   mips_pkg::word_t    ex_pc, ex_rs_val, ex_rt_val, ex_imm, ex_pc4;
   mips_pkg::word_t    ex_a, ex_rt_fwd, ex_b, ex_result;
   mips_pkg::reg_idx_t ex_rs, ex_rt, ex_dest;
   mips_pkg::alu_op_t  ex_alu_op;
   mips_pkg::fwd_sel_t fwd_a, fwd_b;
   logic [4:0]         ex_shamt;
   logic [25:0]        ex_jump_index;
   logic               ex_use_imm, ex_reg_we, ex_is_load, ex_is_store;
   logic               ex_is_beq, ex_is_bne, ex_is_jump, ex_is_syscall;
   // memory and writeback stages
   mips_pkg::word_t    mem_alu, wb_alu, wb_load, wb_data;
   mips_pkg::reg_idx_t mem_dest, wb_dest;
   logic               mem_reg_we, mem_is_load, mem_is_store, mem_is_syscall;
   logic               wb_reg_we, wb_is_load;

   function automatic mips_pkg::word_t fwd_mux(input mips_pkg::fwd_sel_t sel,
         input mips_pkg::word_t rf_val, input mips_pkg::word_t mem_val,
         input mips_pkg::word_t wb_val);
      case (sel)
         mips_pkg::fwd_mem: return mem_val;
         mips_pkg::fwd_wb:  return wb_val;
         default:           return rf_val;
      endcase
   endfunction

   mips_fetch u_fetch (
      .clk(clk), .rst_b(rst_b), .enable(!stall && !halted), .pc_sel(pc_sel),
      .branch_target(branch_target), .jump_target(jump_target),
      .pc(pc), .inst_addr(inst_addr)
   );

   // a flush turns the fetch/decode word into a nop
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         if_id_inst <= '0;
      end else if (flush) begin
         if_id_inst <= '0;
      end else if (!stall) begin
         if_id_inst <= inst;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         if_id_pc <= pc;
      end
   end

   mips_decode u_decode (
      .inst(if_id_inst), .rs(id_rs), .rt(id_rt), .rd_dest(id_dest), .imm(id_imm),
      .alu_op(id_alu_op), .use_imm(id_use_imm), .reg_we(id_reg_we),
      .is_load(id_is_load), .is_store(id_is_store), .is_branch_eq(id_is_beq),
      .is_branch_ne(id_is_bne), .is_jump(id_is_jump), .is_syscall(id_is_syscall),
      .jump_index(id_jump_index)
   );

   // writes stop once halted, the instruction ahead of the syscall has retired
   mips_regfile u_regfile (
      .clk(clk), .rst_b(rst_b), .rs_idx(id_rs), .rt_idx(id_rt), .wr_idx(wb_dest),
      .wr_data(wb_data), .we(wb_reg_we && !halted), .rs_data(id_rs_val), .rt_data(id_rt_val)
   );

   mips_hazard u_hazard (
      .id_rs(id_rs), .id_rt(id_rt), .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dest(ex_dest),
      .ex_reg_we(ex_reg_we), .ex_is_load(ex_is_load), .mem_dest(mem_dest),
      .mem_reg_we(mem_reg_we), .wb_dest(wb_dest), .wb_reg_we(wb_reg_we),
      .redirect(redirect), .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
   );

   // stall and flush both push a bubble into decode/execute
   assign id_kill = stall || flush;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_reg_we <= 1'b0;
         ex_is_load <= 1'b0;
         ex_is_store <= 1'b0;
         ex_is_beq <= 1'b0;
         ex_is_bne <= 1'b0;
         ex_is_jump <= 1'b0;
         ex_is_syscall <= 1'b0;
      end else begin
         ex_reg_we <= id_reg_we && !id_kill;
         ex_is_load <= id_is_load && !id_kill;
         ex_is_store <= id_is_store && !id_kill;
         ex_is_beq <= id_is_beq && !id_kill;
         ex_is_bne <= id_is_bne && !id_kill;
         ex_is_jump <= id_is_jump && !id_kill;
         ex_is_syscall <= id_is_syscall && !id_kill;
      end
   end

   always_ff @(posedge clk) begin
      ex_pc <= if_id_pc;
      ex_rs_val <= id_rs_val;
      ex_rt_val <= id_rt_val;
      ex_imm <= id_imm;
      ex_rs <= id_rs;
      ex_rt <= id_rt;
      ex_dest <= id_dest;
      ex_shamt <= if_id_inst[10:6];
      ex_jump_index <= id_jump_index;
      ex_alu_op <= id_alu_op;
      ex_use_imm <= id_use_imm;
   end

   // operand forwarding from memory and writeback
   assign ex_a = fwd_mux(fwd_a, ex_rs_val, mem_alu, wb_data);
   assign ex_rt_fwd = fwd_mux(fwd_b, ex_rt_val, mem_alu, wb_data);
   assign ex_b = ex_use_imm ? ex_imm : ex_rt_fwd;

   mips_alu u_alu (
      .op(ex_alu_op), .a(ex_a), .b(ex_b), .shamt(ex_shamt),
      .result(ex_result), .equal(ex_equal)
   );

   // branch and jump targets are relative to the delay slot address
   assign ex_pc4 = ex_pc + 32'd4;
   assign branch_target = ex_pc4 + {ex_imm[29:0], 2'b00};
   assign jump_target = {ex_pc4[31:28], ex_jump_index, 2'b00};

   assign redirect = ex_is_jump || (ex_is_beq && ex_equal) || (ex_is_bne && !ex_equal);
   assign pc_sel = ex_is_jump ? mips_pkg::pc_jump :
                   redirect   ? mips_pkg::pc_branch : mips_pkg::pc_seq;

   // execute/memory and memory/writeback control fields
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         mem_reg_we <= 1'b0;
         mem_is_load <= 1'b0;
         mem_is_store <= 1'b0;
         mem_is_syscall <= 1'b0;
         wb_reg_we <= 1'b0;
         wb_is_load <= 1'b0;
      end else begin
         mem_reg_we <= ex_reg_we;
         mem_is_load <= ex_is_load;
         mem_is_store <= ex_is_store;
         mem_is_syscall <= ex_is_syscall;
         wb_reg_we <= mem_reg_we;
         wb_is_load <= mem_is_load;
      end
   end

   // mem_wdata carries rt, which is $v0 for a syscall
   always_ff @(posedge clk) begin
      mem_alu <= ex_result;
      mem_wdata <= ex_rt_fwd;
      mem_dest <= ex_dest;
      wb_alu <= mem_alu;
      wb_load <= mem_rdata;
      wb_dest <= mem_dest;
   end

   // data port
   assign mem_addr = mem_alu[mips_pkg::word_w-1:2];
   assign mem_we = mem_is_store && !halted;

   assign wb_data = wb_is_load ? wb_load : wb_alu;

   // exit syscall in memory sets halted, held until reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (mem_is_syscall && mem_wdata == mips_pkg::syscall_exit) begin
         halted <= 1'b1;
      end
   end

endmodule

// ==== verification/mips_programs.svh ====
/*
 * program table for the core testbench, included inside tb_mips_core
 * all programs sit back to back in prog_rom, expected stores use word addresses
 */

localparam int n_progs = 5;
localparam int rom_words = 46;
// this program gets random immediates patched into its first two words
localparam int rand_prog = 0;

// program p is prog_rom[prog_start[p]] onward, prog_len[p] words long
int prog_start [n_progs] = '{0, 9, 20, 27, 39};
int prog_len [n_progs] = '{9, 11, 7, 12, 7};

logic [31:0] prog_rom [rom_words] = '{
   // dependent chain, addi t0 / xori t1 t0 / sub t2 t1 t0 / nor t3 t2 t1
   32'h2008_0000, 32'h3909_0000, 32'h0128_5022, 32'h0149_5827,
   // sll t0 t3 4 / sra t1 t0 3 / sw t1 0 / exit
   32'h000b_4100, 32'h0008_48c3, 32'hac09_0000, 32'h2002_000a, 32'h0000_000c,
   // t0 = -1, t1 = 1 / slt t2 / sltu t3
   32'h2008_ffff, 32'h2009_0001, 32'h0109_502a, 32'h0109_582b,
   // sw t2 4 / sw t3 8 / lui t0 0x1234 / ori t0 0xabcd / sw t0 12 / exit
   32'hac0a_0004, 32'hac0b_0008, 32'h3c08_1234, 32'h3508_abcd, 32'hac08_000c,
   32'h2002_000a, 32'h0000_000c,
   // addi t0 0x1357 / sw t0 16 / lw t1 16 / addi t2 t1 0x100 / sw t2 20 / exit
   32'h2008_1357, 32'hac08_0010, 32'h8c09_0010, 32'h212a_0100, 32'hac0a_0014,
   32'h2002_000a, 32'h0000_000c,
   // t0 = t1 = 5 / beq skips two marker stores at 0x20 and 0x24
   32'h2008_0005, 32'h2009_0005, 32'h1109_0002, 32'hac08_0020, 32'hac08_0024,
   // bne falls through to sw 0x28 / j over sw 0x2c to sw 0x30 / exit
   32'h1509_0001, 32'hac09_0028, 32'h0810_0009, 32'hac08_002c, 32'hac09_0030,
   32'h2002_000a, 32'h0000_000c,
   // v0 = 5 and syscall keeps running / sw 0x38 / exit / sw 0x3c never lands
   32'h2002_0005, 32'h0000_000c, 32'h2008_0077, 32'hac08_0038, 32'h2002_000a,
   32'h0000_000c, 32'hac08_003c
};

// expected stores of program p start at exp_first[p]
int exp_first [n_progs] = '{0, 1, 4, 6, 8};
int exp_count [n_progs] = '{1, 3, 2, 2, 1};
logic [31:0] exp_addr [9] = '{0, 1, 2, 3, 4, 5, 10, 12, 14};
// first entry is filled in from the random immediates
logic [31:0] exp_data [9] = '{
   32'h0, 32'h1, 32'h0, 32'h1234_abcd, 32'h1357, 32'h1457, 32'h5, 32'h5, 32'h77
};

// ==== verification/tb_mips_core.sv ====
/*
 * testbench for the pipelined mips core
 * runs each table program from reset until halted, then checks the store log
 */
module tb_mips_core;

   // text_start as a word address
   localparam logic [31:0] reset_word_addr = 32'h0010_0000;
   localparam int prog_max = 12;
   localparam int halt_timeout = 200;
   localparam int rand_repeats = 3;

   logic        clk;
   logic        rst_b;
   logic [31:0] inst;
   logic [31:0] mem_rdata;
   logic [29:0] inst_addr;
   logic [29:0] mem_addr;
   logic [31:0] mem_wdata;
   logic        mem_we;
   logic        halted;

   logic [31:0] cur_prog [prog_max];
   logic [31:0] dmem [64];
   // every mem_we strobe, as word address and data
   logic [31:0] log_addr [$];
   logic [31:0] log_data [$];
   logic [31:0] want_addr [$];
   logic [31:0] want_data [$];
   integer      seed;

   `include "mips_programs.svh"

   mips_core dut (
      .clk(clk), .rst_b(rst_b), .inst(inst), .mem_rdata(mem_rdata),
      .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_we(mem_we), .halted(halted)
   );

   always #4 clk = ~clk;

   // nop beyond the end of the program
   function automatic logic [31:0] fetch_word(input logic [29:0] addr);
      logic [29:0] idx;
      idx = addr - reset_word_addr[29:0];
      if (idx < prog_max) begin
         return cur_prog[idx];
      end
      return 32'h0;
   endfunction

   // isa result of the random chain, addi sign extends and xori zero extends
   function automatic logic [31:0] chain_result(input logic [15:0] ia, input logic [15:0] ib);
      logic [31:0] t0;
      logic [31:0] t1;
      logic [31:0] t2;
      logic [31:0] t3;
      logic [31:0] sh;
      t0 = {{16{ia[15]}}, ia};
      t1 = t0 ^ {16'h0, ib};
      t2 = t1 - t0;
      t3 = ~(t2 | t1);
      sh = t3 << 4;
      return $signed(sh) >>> 3;
   endfunction

   // both memories answer within the cycle, inputs move 1 unit after the edge
   always @(posedge clk) begin
      #1;
      inst = fetch_word(inst_addr);
      mem_rdata = dmem[mem_addr[5:0]];
   end

   // data memory write and store log, mem_we is stable mid cycle
   always @(negedge clk) begin
      if (mem_we) begin
         log_addr.push_back({2'b00, mem_addr});
         log_data.push_back(mem_wdata);
         dmem[mem_addr[5:0]] = mem_wdata;
      end
   end

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
         input string what);
      if (actual !== expected) begin
         $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   task automatic load_program(input int p);
      logic [31:0] r_a;
      logic [31:0] r_b;
      log_addr.delete();
      log_data.delete();
      want_addr.delete();
      want_data.delete();
      for (int i = 0; i < 64; i++) begin
         dmem[i] = 32'h0;
      end
      for (int i = 0; i < prog_max; i++) begin
         if (i < prog_len[p]) begin
            cur_prog[i] = prog_rom[prog_start[p] + i];
         end else begin
            cur_prog[i] = 32'h0;
         end
      end
      for (int i = 0; i < exp_count[p]; i++) begin
         want_addr.push_back(exp_addr[exp_first[p] + i]);
         want_data.push_back(exp_data[exp_first[p] + i]);
      end
      // fresh immediates for the addi and xori of the chain
      if (p == rand_prog) begin
         r_a = $random(seed);
         r_b = $random(seed);
         cur_prog[0][15:0] = r_a[15:0];
         cur_prog[1][15:0] = r_b[15:0];
         want_data[0] = chain_result(r_a[15:0], r_b[15:0]);
      end
   endtask

   task automatic check_reset_state(input string when);
      check_equal({2'b00, inst_addr}, reset_word_addr, {"inst_addr ", when});
      check_equal(mem_we, 1'b0, {"mem_we ", when});
      check_equal(halted, 1'b0, {"halted ", when});
   endtask

   task automatic start_program(input int p);
      @(posedge clk);
      #1;
      rst_b = 1'b0;
      load_program(p);
      #1;
      check_reset_state("during reset");
      repeat (8) @(posedge clk);
      #1;
      rst_b = 1'b1;
      // still before the first active edge
      #1;
      check_reset_state("after reset");
   endtask

   task automatic wait_for_halt(input int p);
      int cycles;
      cycles = 0;
      while (!halted && cycles < halt_timeout) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!halted) begin
         $display("Timeout: program %0d did not halt within %0d cycles", p, halt_timeout);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_stores(input int p);
      logic [29:0] frozen;
      frozen = inst_addr;
      // a few more cycles while halted, nothing may move or strobe
      repeat (10) @(posedge clk);
      #1;
      check_equal(halted, 1'b1, "halted dropped after the exit syscall");
      check_equal({2'b00, inst_addr}, {2'b00, frozen}, "pc moved while halted");
      check_equal(log_addr.size(), want_addr.size(), $sformatf("program %0d store count", p));
      for (int i = 0; i < want_addr.size(); i++) begin
         check_equal(log_addr[i], want_addr[i], $sformatf("program %0d store %0d address", p, i));
         check_equal(log_data[i], want_data[i], $sformatf("program %0d store %0d data", p, i));
      end
   endtask

   initial begin
      int p;
      seed = 32'he1852a4e;
      clk = 1'b0;
      rst_b = 1'b0;
      inst = 32'h0;
      mem_rdata = 32'h0;
      // the random chain runs again after the fixed table
      for (int r = 0; r < n_progs + rand_repeats; r++) begin
         p = (r < n_progs) ? r : rand_prog;
         $display("running program %0d", p);
         start_program(p);
         wait_for_halt(p);
         check_stores(p);
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+verification
logic/mips_pkg.sv
logic/mips_fetch.sv
logic/mips_decode.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_hazard.sv
logic/mips_core.sv
verification/tb_mips_core.sv
